// File: tb.f
+incdir+hdl
hdl/win5_geom_pkg.sv
hdl/win5_ctrl_pkg.sv
hdl/frame_mem.sv
hdl/scan_counter.sv
hdl/window_ctrl.sv
hdl/line_buffer_bank.sv
hdl/window_buffer_top.sv
verification/tb_window_buffer.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_window_buffer -Mdir obj_dir

out=$(./obj_dir/Vtb_window_buffer 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

// File: verification/tb_window_buffer.sv
`include "win5_params.svh"

module tb_window_buffer;

    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [`WIN_BITS-1:0] wide_t;

    localparam int FRAME_CYCLES      = 217;
    localparam int TIMEOUT_CYCLES    = 3 * 3 * (`FRAME_PIX + FRAME_CYCLES);
    localparam int WINDOWS_PER_FRAME = `IMG_H * (`IMG_W - `WIN + 1);

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic                  wr_en;
    win5_geom_pkg::addr_t  wr_addr;
    win5_geom_pkg::pixel_t wr_data;
    wide_t                 window;
    logic                  window_valid;
    win5_geom_pkg::row_t   win_row;
    win5_geom_pkg::col_t   win_col;
    logic                  busy;
    logic                  frame_done;

    // model images, prev_img feeds the rows above the top.
    win5_geom_pkg::pixel_t cur_img [`FRAME_PIX];
    win5_geom_pkg::pixel_t prev_img [`FRAME_PIX];

    logic [31:0] lfsr = 32'h1fa7a123;
    int cycles = 0;
    int total_windows = 0;
    int done_count = 0;
    int exp_row = 0;
    int exp_col = `WIN - 1;

    window_buffer_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .window       (window),
        .window_valid (window_valid),
        .win_row      (win_row),
        .win_col      (win_col),
        .busy         (busy),
        .frame_done   (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_eq(input string name, input wide_t expected, input wide_t actual);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic win5_geom_pkg::pixel_t random_pixel();
        win5_geom_pkg::pixel_t p;
        p = '0;
        for (int i = 0; i < `PIX_W; i++) begin
            p = {p[`PIX_W-2:0], lfsr_bit()};
        end
        return p;
    endfunction

    function automatic win5_geom_pkg::pixel_t model_pixel(input int r, input int c);
        if (r < 0) begin
            return prev_img[(r + `IMG_H) * `IMG_W + c]; // lines kept from last frame.
        end
        return cur_img[r * `IMG_W + c];
    endfunction

    // bottom-right pixel at (r, c), slot lr*WIN + lc.
    function automatic wide_t model_window(input int r, input int c);
        wide_t w;
        w = '0;
        for (int lr = 0; lr < `WIN; lr++) begin
            for (int lc = 0; lc < `WIN; lc++) begin
                w[(lr*`WIN + lc)*`PIX_W +: `PIX_W] =
                    model_pixel(r - `WIN + 1 + lr, c - `WIN + 1 + lc);
            end
        end
        return w;
    endfunction

    // outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (rst_n && window_valid) begin
            check_eq("win_row", wide_t'(exp_row), wide_t'(win_row));
            check_eq("win_col", wide_t'(exp_col), wide_t'(win_col));
            check_eq("window", model_window(exp_row, exp_col), window);
            total_windows = total_windows + 1;
            if (exp_col == `IMG_W - 1) begin
                exp_col = `WIN - 1;
                exp_row = (exp_row == `IMG_H - 1) ? 0 : exp_row + 1;
            end else begin
                exp_col = exp_col + 1;
            end
        end
        if (rst_n && frame_done) begin
            // last window must already be out.
            check_eq("win_row at frame_done", wide_t'(0), wide_t'(exp_row));
            check_eq("win_col at frame_done", wide_t'(`WIN - 1), wide_t'(exp_col));
            done_count = done_count + 1;
        end
    end

    task automatic load_frame(input bit all_max);
        win5_geom_pkg::pixel_t pix;
        for (int a = 0; a < `FRAME_PIX; a++) begin
            prev_img[a] = cur_img[a];
        end
        for (int a = 0; a < `FRAME_PIX; a++) begin
            @(posedge clk);
            #2;
            check_eq("busy", '0, wide_t'(busy));
            check_eq("window_valid", '0, wide_t'(window_valid));
            check_eq("frame_done", '0, wide_t'(frame_done));
            if (all_max) begin
                pix = '1;
            end else begin
                pix = random_pixel();
            end
            cur_img[a] = pix;
            wr_en = 1'b1;
            wr_addr = win5_geom_pkg::addr_t'(a);
            wr_data = pix;
        end
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic run_frame(input bit poke_start);
        int done_before;
        int windows_before;
        done_before = done_count;
        windows_before = total_windows;
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (poke_start) begin
            while (total_windows < windows_before + 40) begin
                @(posedge clk);
            end
            #2;
            check_eq("busy", wide_t'(1), wide_t'(busy));
            start = 1'b1; // ignored mid-frame.
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        while (done_count == done_before) begin
            @(posedge clk);
        end
        do begin
            @(negedge clk);
        end while (busy);
        check_eq("frame_done pulses", wide_t'(done_before + 1), wide_t'(done_count));
        check_eq("windows per frame", wide_t'(WINDOWS_PER_FRAME),
                 wide_t'(total_windows - windows_before));
        // no second frame may follow.
        repeat (3) begin
            @(negedge clk);
            check_eq("busy after frame", '0, wide_t'(busy));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        for (int a = 0; a < `FRAME_PIX; a++) begin
            cur_img[a] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_eq("window_valid", '0, wide_t'(window_valid));
        check_eq("frame_done", '0, wide_t'(frame_done));
        check_eq("busy", '0, wide_t'(busy));

        load_frame(1'b0);
        run_frame(1'b0);
        load_frame(1'b0);
        run_frame(1'b1);
        load_frame(1'b1);
        run_frame(1'b0);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: hdl/window_buffer_top.sv
`include "win5_params.svh"

module window_buffer_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   wr_en,
    input  win5_geom_pkg::addr_t   wr_addr,
    input  win5_geom_pkg::pixel_t  wr_data,
    output logic [`WIN_BITS-1:0]   window,
    output logic                   window_valid,
    output win5_geom_pkg::row_t    win_row,
    output win5_geom_pkg::col_t    win_col,
    output logic                   busy,
    output logic                   frame_done
);

    win5_geom_pkg::row_t   row;
    win5_geom_pkg::col_t   col;
    win5_geom_pkg::addr_t  rd_addr;
    win5_geom_pkg::pixel_t rd_data;
    logic                  count_en;
    logic                  clear;
    logic                  col_eq_max;
    logic                  col_ge_threshold;
    logic                  row_eq_max;

    assign rd_addr = win5_geom_pkg::addr_t'(row * `IMG_W + col);

    frame_mem mem0 (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    scan_counter cnt0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .clear            (clear),
        .count_en         (count_en),
        .row              (row),
        .col              (col),
        .col_eq_max       (col_eq_max),
        .col_ge_threshold (col_ge_threshold),
        .row_eq_max       (row_eq_max)
    );

    window_ctrl ctrl0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .col_eq_max       (col_eq_max),
        .col_ge_threshold (col_ge_threshold),
        .row_eq_max       (row_eq_max),
        .count_en         (count_en),
        .clear            (clear),
        .window_valid     (window_valid),
        .frame_done       (frame_done),
        .busy             (busy)
    );

    line_buffer_bank bank0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift_en (count_en), // one shift per scan step.
        .pixel    (rd_data),
        .col      (col),
        .row      (row),
        .window   (window),
        .win_row  (win_row),
        .win_col  (win_col)
    );

endmodule

// File: hdl/line_buffer_bank.sv
`include "win5_params.svh"

module line_buffer_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   shift_en,
    input  win5_geom_pkg::pixel_t  pixel,
    input  win5_geom_pkg::col_t    col,
    input  win5_geom_pkg::row_t    row,
    output logic [`WIN_BITS-1:0]   window,
    output win5_geom_pkg::row_t    win_row,
    output win5_geom_pkg::col_t    win_col
);

    // line 0 is the oldest row, line WIN-2 the row just above the scan.
    win5_geom_pkg::pixel_t line_mem [`WIN-1][`IMG_W];

    // win_q[r][c], row 0 oldest line, column 0 oldest pixel.
    win5_geom_pkg::pixel_t win_q [`WIN][`WIN];

    // vertical slice at the current column.
    win5_geom_pkg::pixel_t col_pix [`WIN];

    always_comb begin
        for (int l = 0; l < `WIN - 1; l++) begin
            col_pix[l] = line_mem[l][col];
        end
        col_pix[`WIN-1] = pixel; // bottom of the window is the live pixel.
    end

    // cleared lines give zero rows above the top of the first frame.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int l = 0; l < `WIN - 1; l++) begin
                for (int c = 0; c < `IMG_W; c++) begin
                    line_mem[l][c] <= '0;
                end
            end
        end else if (shift_en) begin
            for (int l = 0; l < `WIN - 2; l++) begin
                line_mem[l][col] <= line_mem[l+1][col];
            end
            line_mem[`WIN-2][col] <= pixel;
        end
    end

    // shift columns in from the right.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `WIN; r++) begin
                for (int c = 0; c < `WIN; c++) begin
                    win_q[r][c] <= '0;
                end
            end
        end else if (shift_en) begin
            for (int r = 0; r < `WIN; r++) begin
                for (int c = 0; c < `WIN - 1; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
                win_q[r][`WIN-1] <= col_pix[r];
            end
        end
    end

    // position of the newest pixel, bottom right.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_row <= '0;
            win_col <= '0;
        end else if (shift_en) begin
            win_row <= row;
            win_col <= col;
        end
    end

    // slot r*WIN + c.
    always_comb begin
        for (int r = 0; r < `WIN; r++) begin
            for (int c = 0; c < `WIN; c++) begin
                window[(r*`WIN + c)*`PIX_W +: `PIX_W] = win_q[r][c];
            end
        end
    end

endmodule

// File: hdl/window_ctrl.sv
module window_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic col_eq_max,
    input  logic col_ge_threshold,
    input  logic row_eq_max,
    output logic count_en,
    output logic clear,
    output logic window_valid,
    output logic frame_done,
    output logic busy
);

    win5_ctrl_pkg::ctrl_state_e state;
    win5_ctrl_pkg::ctrl_state_e next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= win5_ctrl_pkg::st_idle;
            window_valid <= 1'b0;
        end else begin
            state        <= next_state;
            window_valid <= count_en & col_ge_threshold; // lines up with window regs.
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            win5_ctrl_pkg::st_idle: begin
                if (start) begin
                    next_state = win5_ctrl_pkg::st_start;
                end
            end
            win5_ctrl_pkg::st_start: begin
                next_state = win5_ctrl_pkg::st_start_col;
            end
            win5_ctrl_pkg::st_start_col: begin
                if (col_ge_threshold) begin
                    next_state = win5_ctrl_pkg::st_col_out;
                end
            end
            win5_ctrl_pkg::st_col_out: begin
                // last pixel of the frame skips the row-end stall.
                if (col_eq_max && row_eq_max) begin
                    next_state = win5_ctrl_pkg::st_finish_all;
                end else if (col_eq_max) begin
                    next_state = win5_ctrl_pkg::st_end_col;
                end
            end
            win5_ctrl_pkg::st_end_col: begin
                next_state = win5_ctrl_pkg::st_end_col_2;
            end
            win5_ctrl_pkg::st_end_col_2: begin
                next_state = win5_ctrl_pkg::st_start_col;
            end
            win5_ctrl_pkg::st_finish_all: begin
                next_state = win5_ctrl_pkg::st_done;
            end
            win5_ctrl_pkg::st_done: begin
                next_state = win5_ctrl_pkg::st_idle;
            end
            default: begin
                next_state = win5_ctrl_pkg::st_idle;
            end
        endcase
    end

    // moore outputs.
    always_comb begin
        count_en   = 1'b0;
        clear      = 1'b0;
        frame_done = 1'b0;
        busy       = (state != win5_ctrl_pkg::st_idle);
        case (state)
            win5_ctrl_pkg::st_start:      clear      = 1'b1;
            win5_ctrl_pkg::st_start_col:  count_en   = 1'b1;
            win5_ctrl_pkg::st_col_out:    count_en   = 1'b1;
            win5_ctrl_pkg::st_finish_all: frame_done = 1'b1;
            default:                      count_en   = 1'b0;
        endcase
    end

    done_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) frame_done |=> !frame_done
    ) else $error("frame_done held for more than one cycle");

    no_scan_when_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state inside {win5_ctrl_pkg::st_end_col, win5_ctrl_pkg::st_end_col_2,
                       win5_ctrl_pkg::st_idle}) |-> !count_en
    ) else $error("count_en high in stall or idle state");

endmodule

// File: hdl/scan_counter.sv
`include "win5_params.svh"

module scan_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  count_en,
    output win5_geom_pkg::row_t   row,
    output win5_geom_pkg::col_t   col,
    output logic                  col_eq_max,
    output logic                  col_ge_threshold,
    output logic                  row_eq_max
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (clear) begin
            row <= '0;
            col <= '0;
        end else if (count_en) begin
            if (col_eq_max) begin
                col <= '0;
                // last row wraps too, ready for the next frame.
                if (row_eq_max) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assign col_eq_max = (col == `COL_BITS'(`IMG_W - 1));
    assign row_eq_max = (row == `ROW_BITS'(`IMG_H - 1));

    // enough columns seen for a full window.
    assign col_ge_threshold = (col >= `COL_BITS'(`WIN - 1));

    row_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n) row <= `ROW_BITS'(`IMG_H - 1)
    ) else $error("scan row %0d past last frame row", row);

endmodule

// File: hdl/frame_mem.sv
`include "win5_params.svh"

module frame_mem (
    input  logic                   clk,
    input  logic                   wr_en,
    input  win5_geom_pkg::addr_t   wr_addr,
    input  win5_geom_pkg::pixel_t  wr_data,
    input  win5_geom_pkg::addr_t   rd_addr,
    output win5_geom_pkg::pixel_t  rd_data
);

    // one full frame, raster order.
    win5_geom_pkg::pixel_t mem [`FRAME_PIX];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // scan reads this in the same cycle it steps.
    assign rd_data = mem[rd_addr];

    wr_addr_in_range: assert property (
        @(posedge clk) wr_en |-> (wr_addr < `FRAME_PIX)
    ) else $error("frame_mem write outside frame, addr %0d", wr_addr);

endmodule

// File: hdl/win5_ctrl_pkg.sv
package win5_ctrl_pkg;

    // window controller states.
    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_start      = 3'd1,
        st_start_col  = 3'd2, // filling first columns of a row.
        st_col_out    = 3'd3, // windows flowing.
        st_end_col    = 3'd4,
        st_end_col_2  = 3'd5,
        st_finish_all = 3'd6,
        st_done       = 3'd7
    } ctrl_state_e;

endpackage

// File: hdl/win5_geom_pkg.sv
`include "win5_params.svh"

package win5_geom_pkg;

    // one grey-scale sample.
    typedef logic [`PIX_W-1:0] pixel_t;

    typedef logic [`COL_BITS-1:0] col_t; // 0 .. IMG_W-1.
    typedef logic [`ROW_BITS-1:0] row_t; // 0 .. IMG_H-1.

    // linear frame address, row * IMG_W + col.
    typedef logic [`ADDR_BITS-1:0] addr_t;

endpackage

// File: hdl/win5_params.svh
`ifndef WIN5_PARAMS_SVH
`define WIN5_PARAMS_SVH

// frame geometry.
`define IMG_W 16
`define IMG_H 12

`define PIX_W 8

// window side, square.
`define WIN 5

// index widths, sized for the geometry above.
`define COL_BITS 4
`define ROW_BITS 4
`define ADDR_BITS 8

`define FRAME_PIX (`IMG_W * `IMG_H)
`define WIN_BITS (`WIN * `WIN * `PIX_W)

`endif
